// File: sources.f
src/decodePkg.sv
src/instrDecoder.sv
src/writePortCtrl.sv
src/regFile.sv
src/branchResolve.sv
src/decodeStage.sv
verification/decodeStage_checker.sv
verification/decodeStage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sources.f --top-module decodeStage_tb -o decodeStageSim

# The simulation result comes from its printed output
output=$(./obj_dir/decodeStageSim 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

// File: verification/decodeStage_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench of the decode stage with random stimulus from a fixed seed
// A register and link shadow model predicts every output of each cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decodeStage_tb;

   localparam int edgePolls = 8;  // Polls allowed while waiting for one rising edge
   localparam decodePkg::wbPortT noWb = '0;

   logic                 clk;
   logic                 rstN;
   decodePkg::instrWordT instr;
   logic [15:0]          pcNow;
   decodePkg::wbPortT    wbIn;
   logic                 halt;
   logic [15:0]          reg1Data;
   logic [15:0]          reg2Data;
   logic [15:0]          imm;
   decodePkg::ctrlT      ctrl;
   logic                 pcSel;

   logic [15:0] modelRegs [8];  // Register contents as the DUT should hold them
   logic [2:0]  modelShadow;    // Top bit marks a link instruction in writeback

   decodeStage uut (
      .clk      (clk),
      .rstN     (rstN),
      .instr    (instr),
      .pcNow    (pcNow),
      .wbIn     (wbIn),
      .halt     (halt),
      .reg1Data (reg1Data),
      .reg2Data (reg2Data),
      .imm      (imm),
      .ctrl     (ctrl),
      .pcSel    (pcSel)
   );

   always #2 clk = ~clk;  // Rising edges at 2, 6, 10 ns

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic checkData(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
      if (actual !== expected) begin
         reportFailure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic checkCtrl(input string name, input decodePkg::ctrlT expected,
                            input decodePkg::ctrlT actual);
      if (actual !== expected) begin
         reportFailure($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
      end
   endtask

   task automatic checkBit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         reportFailure($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
      end
   endtask

   // Polls on odd nanoseconds, which never coincide with a clock edge
   task automatic waitRise(input string what);
      int   polls;
      logic wasLow;
      logic seen;
      polls  = 0;
      seen   = 1'b0;
      wasLow = (clk === 1'b0);
      while (!seen && polls < edgePolls) begin
         #2;
         polls++;
         if (clk === 1'b0) begin
            wasLow = 1'b1;
         end else if (clk === 1'b1 && wasLow) begin
            seen = 1'b1;  // Now 1 ns past the rising edge
         end
      end
      if (!seen) begin
         reportFailure($sformatf("No rising clock edge arrived during %s", what));
      end
   endtask

   function automatic logic [15:0] signExtend(input logic [15:0] field, input int width);
      logic [15:0] upper;
      upper = 16'hFFFF << width;
      if (field[width-1]) begin
         return field | upper;
      end
      return field & ~upper;
   endfunction

   // Opcode classes straight from the instruction set table
   function automatic decodePkg::ctrlT expectCtrl(input logic [15:0] w);
      decodePkg::ctrlT c;
      logic [4:0]      op;
      op = w[15:11];
      c  = '0;
      c.isBranch = (op[4:2] == 3'b011);
      if (c.isBranch) begin
         c.brCond = op[1:0];
      end
      c.isJump = (op[4:2] == 3'b001);  // 00100 to 00111 are the four jumps
      c.isLink = (op == 5'b00110) || (op == 5'b00111);
      c.isHalt = (op == 5'b00000);
      return c;
   endfunction

   function automatic logic [15:0] expectImm(input logic [15:0] w);
      logic [4:0] op;
      op = w[15:11];
      if (op[4:2] == 3'b010) begin
         return signExtend({11'b0, w[4:0]}, 5);
      end else if (op[4:2] == 3'b011 || op == 5'b00101 || op == 5'b00111) begin
         return signExtend({8'b0, w[7:0]}, 8);
      end else if (op == 5'b00100 || op == 5'b00110) begin
         return signExtend({5'b0, w[10:0]}, 11);
      end
      return 16'h0000;
   endfunction

   function automatic logic expectPcSel(input logic [15:0] w, input logic [15:0] rsVal,
                                        input logic haltV);
      decodePkg::ctrlT c;
      logic            taken;
      c = expectCtrl(w);
      case (c.brCond)
         2'b00:   taken = (rsVal == 16'h0000);
         2'b01:   taken = (rsVal != 16'h0000);
         2'b10:   taken = rsVal[15];
         default: taken = !rsVal[15];
      endcase
      return !haltV && (c.isJump || (c.isBranch && taken));
   endfunction

   function automatic decodePkg::wbPortT makeWb(input logic en, input logic [2:0] addr,
                                                input logic [15:0] data);
      decodePkg::wbPortT p;
      p.en   = en;
      p.addr = addr;
      p.data = data;
      return p;
   endfunction

   function automatic logic [15:0] makeWord(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [4:0] low);
      return {op, rs, rt, low};
   endfunction

   function automatic logic [15:0] evenPc();
      return 16'($urandom) & 16'hFFFE;
   endfunction

   function automatic logic [15:0] randomNonLink();
      logic [15:0] w;
      w = 16'($urandom);
      if (w[15:12] == 4'b0011) begin
         w[12] = 1'b0;  // JAL and JALR turn into J and JR
      end
      return w;
   endfunction

   // Kind 0 link, 1 plain jump, 2 branch, 3 ALU immediate, 4 ALU register, else any word
   function automatic logic [15:0] randomOfKind(input int kind);
      logic [4:0] op;
      case (kind)
         0:       op = {4'b0011, 1'($urandom)};
         1:       op = {4'b0010, 1'($urandom)};
         2:       op = {3'b011, 2'($urandom)};
         3:       op = {3'b010, 2'($urandom)};
         4:       op = 5'b11011;
         default: op = 5'($urandom);
      endcase
      return {op, 11'($urandom)};
   endfunction

   function automatic logic [15:0] probeValue(input int i);
      case (i)
         0:       return 16'h0000;
         1:       return 16'h8000;  // Most negative value
         2:       return 16'h0001;
         3:       return 16'h7FFF;
         default: return 16'hFFFF;
      endcase
   endfunction

   // Applies the write rule and the shadow shift of the coming edge
   task automatic updateModel(input logic [15:0] word, input logic [15:0] pc,
                              input decodePkg::wbPortT wb);
      logic isLink;
      isLink = (word[15:12] == 4'b0011);
      if (isLink) begin
         modelRegs[7] = pc + 16'd2;
      end else if (wb.en && !modelShadow[2]) begin
         modelRegs[wb.addr] = wb.data;
      end
      modelShadow = {modelShadow[1:0], isLink};
   endtask

   // Drives one instruction, checks all outputs 1 ns before the edge, then steps the model
   task automatic runCycle(input string testName, input logic [15:0] word,
                           input logic [15:0] pc, input decodePkg::wbPortT wb,
                           input logic haltV);
      instr = word;
      pcNow = pc;
      wbIn  = wb;
      halt  = haltV;
      #2;
      checkCtrl({testName, " ctrl"}, expectCtrl(word), ctrl);
      checkData({testName, " imm"}, expectImm(word), imm);
      checkData({testName, " reg1Data"}, modelRegs[word[10:8]], reg1Data);
      checkData({testName, " reg2Data"}, modelRegs[word[7:5]], reg2Data);
      checkBit({testName, " pcSel"},
               expectPcSel(word, modelRegs[word[10:8]], haltV), pcSel);
      updateModel(word, pc, wb);
      waitRise(testName);
   endtask

   task automatic flushShadow();
      for (int i = 0; i < 3; i++) begin
         runCycle("flush", randomNonLink(), evenPc(), noWb, 1'b0);
      end
   endtask

   initial begin
      logic [15:0] pc;
      logic [15:0] word;
      logic [2:0]  rsSel;
      void'($urandom(37090));
      clk         = 1'b0;
      rstN        = 1'b0;
      instr       = '0;
      pcNow       = 16'h0000;
      wbIn        = noWb;
      halt        = 1'b0;
      modelShadow = 3'b000;
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = 16'h0000;
      end
      #1;  // All later activity sits on odd nanoseconds
      for (int i = 0; i < 8; i++) begin
         waitRise("reset");
      end
      rstN = 1'b1;

      // Every register reads zero on both ports
      for (int i = 0; i < 8; i++) begin
         runCycle("resetRead", makeWord(5'b11011, 3'(i), 3'(7 - i), 5'd0), 16'h0000,
                  noWb, 1'b0);
      end

      // Rs of each instruction reads back the address written in the cycle before
      rsSel = 3'($urandom);
      for (int i = 0; i < 48; i++) begin
         word        = randomNonLink();
         word[10:8]  = rsSel;
         rsSel       = 3'($urandom);
         runCycle("writeback", word, evenPc(),
                  makeWb(1'($urandom), rsSel, 16'($urandom)), 1'($urandom));
      end

      for (int i = 0; i < 64; i++) begin
         runCycle("decode", 16'($urandom), evenPc(), noWb, 1'($urandom));
      end

      // Each condition against zero, negative and positive Rs values
      flushShadow();
      for (int c = 0; c < 4; c++) begin
         for (int v = 0; v < 5; v++) begin
            rsSel = 3'($urandom);
            pc    = evenPc();
            word  = makeWord({3'b011, 2'(c)}, rsSel, 3'($urandom), 5'($urandom));
            runCycle("branchLoad", randomNonLink(), pc, makeWb(1'b1, rsSel, probeValue(v)),
                     1'b0);
            runCycle("branch", word, pc, noWb, 1'b0);
            runCycle("branchHalt", word, pc, noWb, 1'b1);
         end
      end
      for (int j = 0; j < 4; j++) begin
         word = makeWord({3'b001, 2'(j)}, 3'($urandom), 3'($urandom), 5'($urandom));
         runCycle("jump", word, evenPc(), noWb, 1'b0);
         runCycle("jumpHalt", word, evenPc(), noWb, 1'b1);
      end

      // Link write, then writebacks one, two and three cycles later
      for (int k = 0; k < 2; k++) begin
         flushShadow();
         pc = evenPc();
         runCycle("linkIssue", makeWord({4'b0011, 1'(k)}, 3'($urandom), 3'($urandom),
                  5'($urandom)), pc, noWb, 1'b0);
         runCycle("linkReturn", makeWord(5'b11011, 3'd7, 3'd7, 5'd0), pc + 16'd2,
                  makeWb(1'b1, 3'd1, 16'($urandom)), 1'b0);
         runCycle("linkWb2", makeWord(5'b11011, 3'd1, 3'd0, 5'd0), pc + 16'd4,
                  makeWb(1'b1, 3'd2, 16'($urandom)), 1'b0);
         runCycle("linkWb3", makeWord(5'b11011, 3'd2, 3'd3, 5'd0), pc + 16'd6,
                  makeWb(1'b1, 3'd3, ~modelRegs[3]), 1'b0);  // This one is dropped
         runCycle("linkCheck12", makeWord(5'b11011, 3'd1, 3'd2, 5'd0), pc + 16'd8,
                  noWb, 1'b0);
         runCycle("linkCheck3", makeWord(5'b11011, 3'd3, 3'd7, 5'd0), pc + 16'd10,
                  noWb, 1'b0);
      end

      // Two link instructions overlap in the shadow
      flushShadow();
      pc = evenPc();
      runCycle("linkPair", makeWord(5'b00110, 3'd0, 3'd0, 5'd3), pc, noWb, 1'b0);
      runCycle("linkPair", makeWord(5'b00111, 3'd5, 3'd0, 5'd9), pc + 16'd2, noWb, 1'b0);
      for (int i = 0; i < 5; i++) begin
         runCycle("linkPairWb", makeWord(5'b11011, 3'(i), 3'd7, 5'd0), pc + 16'(4 + 2 * i),
                  makeWb(1'b1, 3'(i), 16'($urandom)), 1'b0);
      end
      // R1 and R2 keep their old values, R0, R3 and R4 took the writeback
      for (int i = 0; i < 5; i += 2) begin
         runCycle("linkPairCheck", makeWord(5'b11011, 3'(i), 3'(i + 1), 5'd0),
                  pc + 16'(14 + i), noWb, 1'b0);
      end

      for (int i = 0; i < 400; i++) begin
         runCycle("mix", randomOfKind(int'($urandom_range(0, 5))), evenPc(),
                  makeWb(($urandom_range(0, 3) != 0), 3'($urandom), 16'($urandom)),
                  ($urandom_range(0, 3) == 0));
      end

      $display("test passed");
      $finish;
   end

endmodule

// File: verification/decodeStage_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the decode stage strobes
// Bound into every decodeStage instance
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module decodeStage_checker (
   input logic              clk,
   input logic              rstN,
   input logic              halt,
   input logic              pcSel,
   input decodePkg::ctrlT   ctrl,
   input decodePkg::wbPortT wrPort  // Write into the register file after arbitration
);

   // Halt freezes the PC whatever is decoded
   haltBlocksPcSel: assert property (@(posedge clk) disable iff (!rstN)
      halt |-> !pcSel)
      else $error("pcSel is high while halt is high");

   selNeedsCause: assert property (@(posedge clk) disable iff (!rstN)
      pcSel |-> (ctrl.isBranch || ctrl.isJump))  // Only branches and jumps redirect
      else $error("pcSel is high without a branch or jump decoded");

   // The return address always goes to the link register
   linkWritesR7: assert property (@(posedge clk) disable iff (!rstN)
      ctrl.isLink |-> (wrPort.en &&
                       wrPort.addr == decodePkg::regAddrW'(decodePkg::linkReg)))
      else $error("Link write does not target R7");

endmodule

bind decodeStage decodeStage_checker uChecker (
   .clk    (clk),
   .rstN   (rstN),
   .halt   (halt),
   .pcSel  (pcSel),
   .ctrl   (ctrl),
   .wrPort (wrPort)
);

// File: src/decodeStage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Decode stage top level
// Decoder feeds the register file and branch logic, write control owns the write port
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  logic                           clk,
   input  logic                           rstN,
   input  decodePkg::instrWordT           instr,
   input  logic [decodePkg::dataW-1:0]    pcNow,
   input  decodePkg::wbPortT              wbIn,
   input  logic                           halt,
   output logic [decodePkg::dataW-1:0]    reg1Data,
   output logic [decodePkg::dataW-1:0]    reg2Data,
   output logic [decodePkg::dataW-1:0]    imm,
   output decodePkg::ctrlT                ctrl,
   output logic                           pcSel
);

   logic [decodePkg::regAddrW-1:0] rsAddr;
   logic [decodePkg::regAddrW-1:0] rtAddr;
   decodePkg::wbPortT              wrPort;  // Final write into the register file

   instrDecoder uDecoder (
      .instr  (instr),
      .rsAddr (rsAddr),
      .rtAddr (rtAddr),
      .ctrl   (ctrl),
      .imm    (imm)
   );

   writePortCtrl uWriteCtrl (
      .clk    (clk),
      .rstN   (rstN),
      .isLink (ctrl.isLink),
      .pcNow  (pcNow),
      .wbIn   (wbIn),
      .wrPort (wrPort)
   );

   regFile uRegFile (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddr1 (rsAddr),
      .rdAddr2 (rtAddr),
      .wrPort  (wrPort),
      .rdData1 (reg1Data),
      .rdData2 (reg2Data)
   );

   // Conditions test the Rs value read this cycle
   branchResolve uBranch (
      .ctrl   (ctrl),
      .rsData (reg1Data),
      .halt   (halt),
      .pcSel  (pcSel)
   );

endmodule

`default_nettype wire

// File: src/branchResolve.sv
// ~~~~~~~~~~~~~~~~~~~~
// Branch and jump resolution into the PC-select strobe
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
   input  decodePkg::ctrlT                ctrl,
   input  logic [decodePkg::dataW-1:0]    rsData,
   input  logic                           halt,
   output logic                           pcSel
);

   logic rsZero;
   logic rsNeg;
   logic taken;

   assign rsZero = (rsData == '0);
   assign rsNeg  = rsData[decodePkg::dataW-1];  // Sign bit of Rs

   always_comb begin
      taken = 1'b0;
      case (ctrl.brCond)
         decodePkg::condEqz: taken = rsZero;
         decodePkg::condNez: taken = !rsZero;
         decodePkg::condLtz: taken = rsNeg;
         decodePkg::condGez: taken = !rsNeg;   // Zero counts as not negative
         default:            taken = 1'b0;
      endcase
   end

   // Jumps always redirect, and halt freezes the PC
   assign pcSel = !halt && (ctrl.isJump || (ctrl.isBranch && taken));

endmodule

`default_nettype wire

// File: src/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~
// Eight-entry register file of the decode stage
// Two combinational reads and one write at the rising edge, no write bypass
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [decodePkg::regAddrW-1:0]  rdAddr1,
   input  logic [decodePkg::regAddrW-1:0]  rdAddr2,
   input  decodePkg::wbPortT               wrPort,
   output logic [decodePkg::dataW-1:0]     rdData1,
   output logic [decodePkg::dataW-1:0]     rdData2
);

   logic [decodePkg::dataW-1:0] regs [decodePkg::numRegs];

   // All registers start at zero
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < decodePkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrPort.en) begin
         regs[wrPort.addr] <= wrPort.data;
      end
   end

   // Reads see the value from before this edge
   assign rdData1 = regs[rdAddr1];  // Rs
   assign rdData2 = regs[rdAddr2];  // Rt

endmodule

`default_nettype wire

// File: src/writePortCtrl.sv
// ~~~~~~~~~~~~~~~~~~~~
// Register file write port control
// Link writes go first, and a link instruction's own writeback is dropped
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module writePortCtrl (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           isLink,
   input  logic [decodePkg::dataW-1:0]    pcNow,
   input  decodePkg::wbPortT              wbIn,
   output decodePkg::wbPortT              wrPort
);

   // Bit 0 follows the instruction into execute, the top bit marks writeback
   logic [decodePkg::linkShadowDepth-1:0] linkShadow;
   logic wbIsLink;  // The instruction now in writeback was JAL or JALR
   logic [decodePkg::dataW-1:0] returnAddr;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         linkShadow <= '0;
      end else begin
         linkShadow <= {linkShadow[decodePkg::linkShadowDepth-2:0], isLink};
      end
   end

   assign wbIsLink   = linkShadow[decodePkg::linkShadowDepth-1];
   assign returnAddr = pcNow + decodePkg::dataW'(decodePkg::instrBytes);

   always_comb begin
      // Default passes the writeback fields through with the strobe low
      wrPort      = wbIn;
      wrPort.en   = 1'b0;
      if (isLink) begin
         wrPort.en   = 1'b1;
         wrPort.addr = decodePkg::regAddrW'(decodePkg::linkReg);
         wrPort.data = returnAddr;
      end else if (wbIn.en && !wbIsLink) begin
         wrPort.en = 1'b1;  // Ordinary writeback lands
      end
   end

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Instruction decoder of the decode stage
// Splits the word into register addresses, control flags and the immediate
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  decodePkg::instrWordT             instr,
   output logic [decodePkg::regAddrW-1:0]   rsAddr,
   output logic [decodePkg::regAddrW-1:0]   rtAddr,
   output decodePkg::ctrlT                  ctrl,
   output logic [decodePkg::dataW-1:0]      imm
);

   logic [decodePkg::opW-1:0] opcode;
   logic isAluImm;
   logic isBrOp;
   logic isJumpOp;
   logic isLinkOp;
   logic usesImm8;  // Branches and register jumps share the 8-bit field

   assign opcode = instr.jFmt.opcode;  // Opcode sits in the same bits in every view

   // Rs and Rt never move between formats, so the R view serves all
   assign rsAddr = instr.rFmt.rs;
   assign rtAddr = instr.rFmt.rt;

   assign isAluImm = (opcode[4:2] == decodePkg::aluImmGroup);
   assign isBrOp   = (opcode[4:2] == decodePkg::brGroup);
   assign isLinkOp = (opcode == decodePkg::opJal) || (opcode == decodePkg::opJalr);
   assign isJumpOp = (opcode == decodePkg::opJ) || (opcode == decodePkg::opJr) || isLinkOp;
   assign usesImm8 = isBrOp || (opcode == decodePkg::opJr) || (opcode == decodePkg::opJalr);

   always_comb begin
      ctrl          = '0;
      ctrl.isBranch = isBrOp;
      ctrl.isJump   = isJumpOp;
      ctrl.isLink   = isLinkOp;
      ctrl.isHalt   = (opcode == decodePkg::opHalt);
      if (isBrOp) begin
         ctrl.brCond = decodePkg::brCondT'(opcode[1:0]);  // Condition rides in the opcode
      end
   end

   // Immediate selection by format
   always_comb begin
      imm = '0;  // Register format and all other opcodes have no immediate
      if (isAluImm) begin
         imm = decodePkg::sextImm5(instr.iFmt.imm5);
      end else if (usesImm8) begin
         imm = decodePkg::sextImm8(instr.bFmt.imm8);
      end else if ((opcode == decodePkg::opJ) || (opcode == decodePkg::opJal)) begin
         imm = decodePkg::sextDisp11(instr.jFmt.disp11);  // PC relative displacement
      end
   end

endmodule

`default_nettype wire

// File: src/decodePkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes, instruction views and control types of the decode stage
// Every decode file reads these through decodePkg:: scoped names
// ~~~~~~~~~~~~~~~~~~~~
package decodePkg;

   localparam int dataW           = 16;  // Data and instruction width
   localparam int regAddrW        = 3;   // Register address width
   localparam int numRegs         = 2 ** regAddrW;
   localparam int linkReg         = 7;   // JAL and JALR put the return address here
   localparam int linkShadowDepth = 3;   // Decode to writeback distance in stages
   localparam int instrBytes      = 2;   // PC step of one instruction

   // Field widths shared by all formats
   localparam int opW     = 5;
   localparam int funct2W = 2;
   localparam int imm5W   = 5;
   localparam int imm8W   = 8;
   localparam int disp11W = 11;

   // Jump opcodes
   localparam logic [opW-1:0] opJ    = 5'b00100;
   localparam logic [opW-1:0] opJr   = 5'b00101;
   localparam logic [opW-1:0] opJal  = 5'b00110;
   localparam logic [opW-1:0] opJalr = 5'b00111;
   localparam logic [opW-1:0] opAluR = 5'b11011;  // Register format ALU ops
   localparam logic [opW-1:0] opHalt = 5'b00000;

   // Upper three opcode bits that name an instruction group
   localparam logic [2:0] brGroup     = 3'b011;  // Low two bits carry the condition
   localparam logic [2:0] aluImmGroup = 3'b010;

   typedef logic [1:0] brCondT;
   localparam brCondT condEqz = 2'b00;
   localparam brCondT condNez = 2'b01;
   localparam brCondT condLtz = 2'b10;
   localparam brCondT condGez = 2'b11;

   typedef struct packed {
      logic [opW-1:0]      opcode;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rt;
      logic [regAddrW-1:0] rd;
      logic [funct2W-1:0]  funct2;
   } rFmtT;

   typedef struct packed {
      logic [opW-1:0]      opcode;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rd;
      logic [imm5W-1:0]    imm5;
   } iFmtT;

   typedef struct packed {
      logic [opW-1:0]      opcode;
      logic [regAddrW-1:0] rs;
      logic [imm8W-1:0]    imm8;
   } bFmtT;

   typedef struct packed {
      logic [opW-1:0]     opcode;
      logic [disp11W-1:0] disp11;
   } jFmtT;

   // One 16-bit word, read through the view its opcode calls for
   typedef union packed {
      rFmtT rFmt;
      iFmtT iFmt;
      bFmtT bFmt;
      jFmtT jFmt;
   } instrWordT;

   typedef struct packed {
      logic   isBranch;
      brCondT brCond;
      logic   isJump;
      logic   isLink;  // JAL or JALR
      logic   isHalt;
   } ctrlT;

   typedef struct packed {
      logic                en;
      logic [regAddrW-1:0] addr;
      logic [dataW-1:0]    data;
   } wbPortT;

   // Sign extension for each immediate format
   function automatic logic [dataW-1:0] sextImm5(input logic [imm5W-1:0] v);
      return {{(dataW - imm5W){v[imm5W-1]}}, v};
   endfunction

   function automatic logic [dataW-1:0] sextImm8(input logic [imm8W-1:0] v);
      return {{(dataW - imm8W){v[imm8W-1]}}, v};
   endfunction

   function automatic logic [dataW-1:0] sextDisp11(input logic [disp11W-1:0] v);
      return {{(dataW - disp11W){v[disp11W-1]}}, v};
   endfunction

endpackage
